/* rtl/acid_auth_fsm.sv */
module acid_auth_fsm import acid_pkg::*; #(
    parameter int READ_LIMIT = 4
) (
    input  logic     clk_sys,
    input  logic     reset,
    acid_bus_if.sink bus,
    input  logic     seq_done,
    output logic     asic_locked,
    output logic     auth_active,
    output logic     challenge_sent,
    output byte_t    auth_resp,
    output byte_t    asic_status
);

    auth_state_t state;
    byte_t       resp_q;

    logic        count_en;
    logic        count_clear;
    logic        limit_hit;

    logic        cart_meta_wr;
    logic        cpu_reg_wr;
    logic        cart_key_ok;
    logic        cpu_key_ok;
    logic        valid_wr;

    // -------------------------------------------------------------------------
    // Decoded bus events
    // -------------------------------------------------------------------------
    assign cart_meta_wr = bus.cart_download && bus.cart_wr &&
                          (bus.cart_addr[24:8] == CART_META_PAGE);
    assign cpu_reg_wr   = bus.cpu_wr;

    assign cart_key_ok = cart_meta_wr && (bus.cart_addr[7:0] == META_AUTH_OFF) &&
                         (bus.cart_data == AUTH_KEY);
    assign cpu_key_ok  = cpu_reg_wr && (bus.cpu_addr[7:0] == REG_AUTH_KEY) &&
                         (bus.cpu_wdata == AUTH_KEY);
    assign valid_wr    = cpu_reg_wr && (bus.cpu_addr[7:0] == REG_COMPUTE) &&
                         (bus.cpu_wdata == AUTH_VALID);

    // Response reads are only counted while a challenge is pending
    assign count_en    = (state == CHALLENGE_SENT) && bus.cpu_rd &&
                         (bus.cpu_addr[7:0] == REG_RESPONSE0);
    assign count_clear = (state != CHALLENGE_SENT);

    auth_read_counter #(
        .READ_LIMIT (READ_LIMIT)
    ) read_counter_i (
        .clk_sys   (clk_sys),
        .reset     (reset),
        .count_en  (count_en),
        .clear     (count_clear),
        .limit_hit (limit_hit)
    );

    // -------------------------------------------------------------------------
    // State register
    // -------------------------------------------------------------------------
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (cart_meta_wr) begin
                        state <= WAIT_KEY;
                    end
                end
                WAIT_KEY: begin
                    if (cart_key_ok || cpu_key_ok) begin
                        state <= WAIT_CHALLENGE;
                    end
                end
                WAIT_CHALLENGE: begin
                    if (cpu_reg_wr && (bus.cpu_addr[7:0] == REG_CHALLENGE0)) begin
                        state <= CHALLENGE_SENT;
                    end
                end
                CHALLENGE_SENT: begin
                    if (limit_hit || valid_wr) begin
                        state <= VERIFIED;
                    end
                end
                VERIFIED: state <= VERIFIED;
                default:  state <= IDLE;
            endcase
        end
    end

    // Pre-computed response to the challenge
    // Every accepted key equals AUTH_KEY
    always_ff @(posedge clk_sys) begin
        if ((state == WAIT_CHALLENGE) && cpu_reg_wr &&
            (bus.cpu_addr[7:0] == REG_CHALLENGE0)) begin
            resp_q <= auth_response(bus.cpu_wdata, AUTH_KEY);
        end
    end

    // Lock flag stays cleared until the next reset
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            asic_locked <= 1'b1;
        end else if ((state == VERIFIED) || seq_done) begin
            asic_locked <= 1'b0;
        end
    end

    assign auth_active    = (state != IDLE);
    assign challenge_sent = (state == CHALLENGE_SENT);
    assign auth_resp      = resp_q;
    assign asic_status    = asic_locked ? 8'h00 : STATUS_UNLOCKED;

endmodule

/* rtl/acid_bus_if.sv */
interface acid_bus_if import acid_pkg::*;;

    // CPU side
    logic       cpu_wr;
    logic       cpu_rd;
    cpu_addr_t  cpu_addr;
    byte_t      cpu_wdata;

    // Cartridge download side
    logic       cart_download;
    logic       cart_wr;
    cart_addr_t cart_addr;
    byte_t      cart_data;

    modport source (output cpu_wr, cpu_rd, cpu_addr, cpu_wdata,
                    output cart_download, cart_wr, cart_addr, cart_data);

    modport sink (input cpu_wr, cpu_rd, cpu_addr, cpu_wdata,
                  input cart_download, cart_wr, cart_addr, cart_data);

endinterface

/* rtl/acid_pkg.sv */
package acid_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] cpu_addr_t;
    typedef logic [24:0] cart_addr_t;

    // -------------------------------------------------------------------------
    // CRTC ports and the unlock sequence
    // -------------------------------------------------------------------------
    localparam cpu_addr_t CRTC_SELECT_ADDR = 16'hBC00;
    localparam cpu_addr_t CRTC_DATA_ADDR   = 16'hBC01;

    localparam int UNLOCK_LEN = 17;

    typedef logic [4:0] unlock_step_t;

    localparam byte_t UNLOCK_SEQ [UNLOCK_LEN] = '{
        8'hFF, 8'h00, 8'hFF, 8'h77, 8'hB3, 8'h51, 8'hA8, 8'hD4, 8'h62,
        8'h39, 8'h9C, 8'h46, 8'h2B, 8'h15, 8'h8A, 8'hCD, 8'hEE
    };

    // -------------------------------------------------------------------------
    // Cartridge metadata page
    // -------------------------------------------------------------------------
    // Upper 17 bits of the image address
    localparam logic [16:0] CART_META_PAGE = 17'h1FF80;
    localparam byte_t       META_KEY_OFF   = 8'h05;
    localparam byte_t       META_AUTH_OFF  = 8'h10;

    // -------------------------------------------------------------------------
    // CPU register offsets, low byte of the address
    // -------------------------------------------------------------------------
    localparam byte_t REG_AUTH_KEY   = 8'hE0;
    localparam byte_t REG_CHALLENGE0 = 8'hE5;
    localparam byte_t REG_COMPUTE    = 8'hE9;
    localparam byte_t REG_RESPONSE0  = 8'hEA;
    localparam byte_t REG_STATUS     = 8'hEE;
    localparam byte_t REG_LOCK       = 8'hEF;

    // Four challenges and four responses
    localparam int CHAL_COUNT = 4;

    localparam byte_t AUTH_KEY        = 8'hA5;
    localparam byte_t AUTH_VALID      = 8'hC3;
    localparam byte_t STATUS_UNLOCKED = 8'hAA;

    typedef enum logic [2:0] {
        IDLE,
        WAIT_KEY,
        WAIT_CHALLENGE,
        CHALLENGE_SENT,
        VERIFIED
    } auth_state_t;

    // Challenge XOR key, rotated left by one
    function automatic byte_t auth_response(input byte_t challenge, input byte_t key);
        byte_t mixed;
        mixed = challenge ^ key;
        return {mixed[6:0], mixed[7]};
    endfunction

endpackage

/* rtl/acid_regs.sv */
module acid_regs import acid_pkg::*; (
    input  logic     clk_sys,
    input  logic     reset,
    acid_bus_if.sink bus,
    input  logic     asic_locked,
    input  logic     auth_active,
    input  logic     challenge_sent,
    input  byte_t    auth_resp,
    input  byte_t    asic_status,
    output byte_t    cpu_data_out
);

    byte_t key;
    byte_t challenge [CHAL_COUNT];
    byte_t response  [CHAL_COUNT];

    logic  wr_ok;
    logic  key_load;
    byte_t reg_off;
    byte_t chal_off;
    byte_t resp_off;

    // -------------------------------------------------------------------------
    // Address decode
    // -------------------------------------------------------------------------
    assign reg_off  = bus.cpu_addr[7:0];

    // Offsets below the base wrap to large values and fall out of range
    assign chal_off = reg_off - REG_CHALLENGE0;
    assign resp_off = reg_off - REG_RESPONSE0;

    assign wr_ok    = bus.cpu_wr && (!asic_locked || auth_active);

    assign key_load = bus.cart_download && bus.cart_wr &&
                      (bus.cart_addr[24:8] == CART_META_PAGE) &&
                      (bus.cart_addr[7:0] == META_KEY_OFF);

    // -------------------------------------------------------------------------
    // Register writes
    // -------------------------------------------------------------------------
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            key <= 8'h00;
            for (int i = 0; i < CHAL_COUNT; i++) begin
                challenge[i] <= 8'h00;
                response[i]  <= 8'h00;
            end
        end else begin
            if (key_load) begin
                key <= bus.cart_data;
            end

            if (wr_ok && (chal_off < byte_t'(CHAL_COUNT))) begin
                challenge[chal_off[1:0]] <= bus.cpu_wdata;
            end

            // Compute all responses at once from the current key
            if (wr_ok && (reg_off == REG_COMPUTE)) begin
                for (int i = 0; i < CHAL_COUNT; i++) begin
                    response[i] <= auth_response(challenge[i], key);
                end
            end
        end
    end

    // -------------------------------------------------------------------------
    // CPU read port
    // -------------------------------------------------------------------------
    always_comb begin
        cpu_data_out = 8'h00;
        if (bus.cpu_rd) begin
            if (resp_off == 8'h00) begin
                // Pending challenge answers from the state machine
                cpu_data_out = challenge_sent ? auth_resp : response[0];
            end else if (resp_off < byte_t'(CHAL_COUNT)) begin
                cpu_data_out = response[resp_off[1:0]];
            end else if (reg_off == REG_STATUS) begin
                cpu_data_out = asic_status;
            end else if (reg_off == REG_LOCK) begin
                cpu_data_out = {7'b0000000, asic_locked};
            end
        end
    end

endmodule

/* rtl/auth_read_counter.sv */
module auth_read_counter #(
    parameter int READ_LIMIT = 4
) (
    input  logic clk_sys,
    input  logic reset,
    input  logic count_en,
    input  logic clear,
    output logic limit_hit
);

    localparam int CW = $clog2(READ_LIMIT + 1);

    logic [CW-1:0] count;

    // The limit-th pulse hits while it is still being counted
    assign limit_hit = count_en && (count == CW'(READ_LIMIT - 1));

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;
        end else if (count_en && (count != CW'(READ_LIMIT))) begin
            count <= count + 1'b1;
        end
    end

endmodule

/* rtl/crtc_unlock_detector.sv */
module crtc_unlock_detector import acid_pkg::*; (
    input  logic       clk_sys,
    input  logic       reset,
    acid_bus_if.sink   bus,
    output logic       seq_done
);

    byte_t        crtc_sel;
    logic         sel_fresh;
    unlock_step_t step;

    logic         sel_wr;
    logic         data_wr;
    logic         step_match;
    logic         last_step;

    assign sel_wr  = bus.cpu_wr && (bus.cpu_addr == CRTC_SELECT_ADDR);

    // Data writes only count against register 0 right after a select
    assign data_wr = bus.cpu_wr && (bus.cpu_addr == CRTC_DATA_ADDR) &&
                     sel_fresh && (crtc_sel == 8'h00);

    assign step_match = (bus.cpu_wdata == UNLOCK_SEQ[step]);
    assign last_step  = (step == unlock_step_t'(UNLOCK_LEN - 1));

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            crtc_sel  <= 8'h00;
            sel_fresh <= 1'b0;
            step      <= '0;
            seq_done  <= 1'b0;
        end else begin
            seq_done <= 1'b0;

            if (sel_wr) begin
                crtc_sel  <= bus.cpu_wdata;
                sel_fresh <= 1'b1;
            end else if (bus.cpu_wr) begin
                sel_fresh <= 1'b0;
            end

            if (data_wr) begin
                if (step_match && last_step) begin
                    seq_done <= 1'b1;
                    step     <= '0;
                end else if (step_match) begin
                    step <= step + 1'b1;
                end else begin
                    // Any wrong byte restarts the sequence
                    step <= '0;
                end
            end
        end
    end

endmodule

/* rtl/gx4000_acid.sv */
module gx4000_acid import acid_pkg::*; #(
    parameter int READ_LIMIT = 4
) (
    input  logic       clk_sys,
    input  logic       reset,

    // CPU port
    input  cpu_addr_t  cpu_addr,
    input  byte_t      cpu_data_in,
    input  logic       cpu_wr,
    input  logic       cpu_rd,
    output byte_t      cpu_data_out,

    // Cartridge download
    input  logic       cart_download,
    input  cart_addr_t cart_addr,
    input  byte_t      cart_data,
    input  logic       cart_wr,

    // Protection status
    output logic       asic_valid,
    output byte_t      asic_status
);

    logic  seq_done;
    logic  asic_locked;
    logic  auth_active;
    logic  challenge_sent;
    byte_t auth_resp;

    acid_bus_if bus ();

    assign bus.cpu_wr        = cpu_wr;
    assign bus.cpu_rd        = cpu_rd;
    assign bus.cpu_addr      = cpu_addr;
    assign bus.cpu_wdata     = cpu_data_in;
    assign bus.cart_download = cart_download;
    assign bus.cart_wr       = cart_wr;
    assign bus.cart_addr     = cart_addr;
    assign bus.cart_data     = cart_data;

    crtc_unlock_detector unlock_i (
        .clk_sys  (clk_sys),
        .reset    (reset),
        .bus      (bus.sink),
        .seq_done (seq_done)
    );

    acid_auth_fsm #(
        .READ_LIMIT (READ_LIMIT)
    ) auth_i (
        .clk_sys        (clk_sys),
        .reset          (reset),
        .bus            (bus.sink),
        .seq_done       (seq_done),
        .asic_locked    (asic_locked),
        .auth_active    (auth_active),
        .challenge_sent (challenge_sent),
        .auth_resp      (auth_resp),
        .asic_status    (asic_status)
    );

    acid_regs regs_i (
        .clk_sys        (clk_sys),
        .reset          (reset),
        .bus            (bus.sink),
        .asic_locked    (asic_locked),
        .auth_active    (auth_active),
        .challenge_sent (challenge_sent),
        .auth_resp      (auth_resp),
        .asic_status    (asic_status),
        .cpu_data_out   (cpu_data_out)
    );

    assign asic_valid = ~asic_locked;

endmodule

/* sim.f */
rtl/acid_pkg.sv
rtl/acid_bus_if.sv
rtl/crtc_unlock_detector.sv
rtl/auth_read_counter.sv
rtl/acid_auth_fsm.sv
rtl/acid_regs.sv
rtl/gx4000_acid.sv
verif/gx4000_acid_properties.sv
verif/gx4000_acid_tb.sv

/* verif/gx4000_acid_properties.sv */
module gx4000_acid_properties import acid_pkg::*; (
    input logic  clk_sys,
    input logic  reset,
    input logic  cpu_rd,
    input byte_t cpu_data_out,
    input logic  asic_valid,
    input byte_t asic_status
);

    timeunit 1ns;
    timeprecision 1ps;

    int assert_failures = 0;

    // -------------------------------------------------------------------------
    // Protection status
    // -------------------------------------------------------------------------
    // Status byte tracks the valid flag
    property status_matches_valid;
        @(posedge clk_sys) disable iff (reset)
            (asic_status == STATUS_UNLOCKED) == asic_valid;
    endproperty

    // Unlock holds until the next reset
    property valid_sticky;
        @(posedge clk_sys) disable iff (reset)
            $past(asic_valid) |-> asic_valid;
    endproperty

    // Device comes out of reset locked
    property locked_after_reset;
        @(posedge clk_sys)
            $fell(reset) |-> (!asic_valid && (asic_status == 8'h00));
    endproperty

    // -------------------------------------------------------------------------
    // CPU read port
    // -------------------------------------------------------------------------
    property read_idle_zero;
        @(posedge clk_sys) !cpu_rd |-> (cpu_data_out == 8'h00);
    endproperty

    status_matches_valid_a: assert property (status_matches_valid)
        else begin
            $error("asic_status disagrees with asic_valid");
            assert_failures++;
        end
    valid_sticky_a: assert property (valid_sticky)
        else begin
            $error("asic_valid fell outside reset");
            assert_failures++;
        end
    locked_after_reset_a: assert property (locked_after_reset)
        else begin
            $error("device not locked when reset was released");
            assert_failures++;
        end
    read_idle_zero_a: assert property (read_idle_zero)
        else begin
            $error("cpu_data_out nonzero while cpu_rd is low");
            assert_failures++;
        end

endmodule

bind gx4000_acid gx4000_acid_properties props_i (
    .clk_sys      (clk_sys),
    .reset        (reset),
    .cpu_rd       (cpu_rd),
    .cpu_data_out (cpu_data_out),
    .asic_valid   (asic_valid),
    .asic_status  (asic_status)
);

/* verif/gx4000_acid_tb.sv */
module gx4000_acid_tb import acid_pkg::*;;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD  = 8;
    localparam int SETTLE      = 2;
    localparam int UNLOCK_WAIT = 4;

    // Rough cycles per test, every bus access takes two cycles
    localparam int TEST_CYCLES    = 15 + 125 + 30 + 20 + 100 + 25;
    localparam int TIMEOUT_CYCLES = 4 * TEST_CYCLES;

    logic        clk_sys;
    logic        reset;
    cpu_addr_t   cpu_addr;
    byte_t       cpu_data_in;
    logic        cpu_wr;
    logic        cpu_rd;
    byte_t       cpu_data_out;
    logic        cart_download;
    cart_addr_t  cart_addr;
    byte_t       cart_data;
    logic        cart_wr;
    logic        asic_valid;
    byte_t       asic_status;

    logic [31:0] rng_state;
    int          error_count = 0;
    int          test_count = 0;
    int          fail_count = 0;
    int          cycle_count = 0;

    gx4000_acid #(
        .READ_LIMIT (4)
    ) gx4000_acid_i (
        .clk_sys       (clk_sys),
        .reset         (reset),
        .cpu_addr      (cpu_addr),
        .cpu_data_in   (cpu_data_in),
        .cpu_wr        (cpu_wr),
        .cpu_rd        (cpu_rd),
        .cpu_data_out  (cpu_data_out),
        .cart_download (cart_download),
        .cart_addr     (cart_addr),
        .cart_data     (cart_data),
        .cart_wr       (cart_wr),
        .asic_valid    (asic_valid),
        .asic_status   (asic_status)
    );

    initial begin
        clk_sys = 1'b0;
        forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
    end

    always @(posedge clk_sys) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Some tests failed");
            $finish;
        end
    end

    // -------------------------------------------------------------------------
    // Helpers
    // -------------------------------------------------------------------------
    function automatic byte_t next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state[7:0];
    endfunction

    // Challenge XOR key, then rotate left by one bit
    function automatic byte_t expected_response(input byte_t challenge, input byte_t key);
        byte_t m;
        m = challenge ^ key;
        return (m << 1) | (m >> 7);
    endfunction

    // Immediate check errors plus bound assertion failures
    function automatic int total_errors();
        return error_count + gx4000_acid_i.props_i.assert_failures;
    endfunction

    task automatic apply_reset();
        @(negedge clk_sys);
        reset         = 1'b1;
        cpu_wr        = 1'b0;
        cpu_rd        = 1'b0;
        cart_download = 1'b0;
        cart_wr       = 1'b0;
        repeat (2) @(negedge clk_sys);
        reset = 1'b0;
    endtask

    task automatic cpu_write(input cpu_addr_t addr, input byte_t data);
        @(negedge clk_sys);
        cpu_addr    = addr;
        cpu_data_in = data;
        cpu_wr      = 1'b1;
        @(negedge clk_sys);
        cpu_wr = 1'b0;
    endtask

    task automatic cart_write(input byte_t off, input byte_t data);
        @(negedge clk_sys);
        cart_addr     = {CART_META_PAGE, off};
        cart_data     = data;
        cart_download = 1'b1;
        cart_wr       = 1'b1;
        @(negedge clk_sys);
        cart_download = 1'b0;
        cart_wr       = 1'b0;
    endtask

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        assert (got === exp) else begin
            $display("ERROR %s: got 0x%02h, expected 0x%02h", name, got, exp);
            error_count++;
        end
    endtask

    // Read data is sampled mid-cycle, before the edge that ends the strobe
    task automatic read_expect(input byte_t off, input byte_t exp);
        byte_t got;
        @(negedge clk_sys);
        cpu_addr = {8'h00, off};
        cpu_rd   = 1'b1;
        #(SETTLE);
        got = cpu_data_out;
        @(negedge clk_sys);
        cpu_rd = 1'b0;
        check_byte($sformatf("cpu_data_out at 0x%02h", off), got, exp);
    endtask

    task automatic send_unlock_bytes(input int count);
        for (int i = 0; i < count; i++) begin
            cpu_write(CRTC_SELECT_ADDR, 8'h00);
            cpu_write(CRTC_DATA_ADDR, UNLOCK_SEQ[i]);
        end
    endtask

    task automatic wait_for_valid(input int max_cycles);
        int waited;
        waited = 0;
        while (!asic_valid && (waited < max_cycles)) begin
            @(negedge clk_sys);
            waited++;
        end
        assert (asic_valid) else begin
            $display("asic_valid did not rise within %0d cycles", max_cycles);
            error_count++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        test_count++;
        if (total_errors() == errors_before) begin
            $display("Test %0d %s: PASS", test_count, name);
        end else begin
            fail_count++;
            $display("Test %0d %s: FAIL, %0d errors", test_count, name,
                     total_errors() - errors_before);
        end
    endtask

    // -------------------------------------------------------------------------
    // Tests
    // -------------------------------------------------------------------------
    initial begin
        byte_t x;
        byte_t key;
        byte_t chal [4];
        int    errs;

        rng_state     = 32'd38964;
        reset         = 1'b1;
        cpu_addr      = '0;
        cpu_data_in   = 8'h00;
        cpu_wr        = 1'b0;
        cpu_rd        = 1'b0;
        cart_download = 1'b0;
        cart_addr     = '0;
        cart_data     = 8'h00;
        cart_wr       = 1'b0;

        errs = total_errors();
        apply_reset();
        check_byte("asic_valid", {7'b0, asic_valid}, 8'h00);
        check_byte("asic_status", asic_status, 8'h00);
        read_expect(REG_LOCK, 8'h01);
        read_expect(REG_STATUS, 8'h00);
        read_expect(8'h42, 8'h00);
        report_test("reset state", errs);

        errs = total_errors();
        apply_reset();
        send_unlock_bytes(8);
        repeat (UNLOCK_WAIT) @(negedge clk_sys);
        check_byte("asic_valid", {7'b0, asic_valid}, 8'h00);
        // Byte 8 of the sequence is 0x62
        cpu_write(CRTC_SELECT_ADDR, 8'h00);
        cpu_write(CRTC_DATA_ADDR, 8'h00);
        repeat (UNLOCK_WAIT) @(negedge clk_sys);
        check_byte("asic_valid", {7'b0, asic_valid}, 8'h00);
        send_unlock_bytes(UNLOCK_LEN);
        wait_for_valid(UNLOCK_WAIT);
        check_byte("asic_status", asic_status, 8'hAA);
        read_expect(REG_LOCK, 8'h00);
        read_expect(REG_STATUS, 8'hAA);
        report_test("unlock sequence", errs);

        errs = total_errors();
        apply_reset();
        x = next_random();
        cart_write(8'h00, next_random());
        cart_write(META_AUTH_OFF, 8'hA5);
        cpu_write({8'h00, REG_CHALLENGE0}, x);
        for (int i = 0; i < 3; i++) begin
            read_expect(REG_RESPONSE0, expected_response(x, 8'hA5));
        end
        repeat (3) @(negedge clk_sys);
        check_byte("asic_valid", {7'b0, asic_valid}, 8'h00);
        read_expect(REG_RESPONSE0, expected_response(x, 8'hA5));
        wait_for_valid(UNLOCK_WAIT);
        report_test("cartridge key", errs);

        errs = total_errors();
        apply_reset();
        cart_write(8'h00, 8'h00);
        cpu_write({8'h00, REG_AUTH_KEY}, 8'hA5);
        cpu_write({8'h00, REG_CHALLENGE0}, next_random());
        cpu_write({8'h00, REG_COMPUTE}, 8'hC3);
        wait_for_valid(UNLOCK_WAIT);
        report_test("cpu key", errs);

        errs = total_errors();
        apply_reset();
        send_unlock_bytes(UNLOCK_LEN);
        wait_for_valid(UNLOCK_WAIT);
        key = next_random();
        cart_write(META_KEY_OFF, key);
        for (int i = 0; i < 4; i++) begin
            chal[i] = next_random();
            cpu_write({8'h00, REG_CHALLENGE0 + byte_t'(i)}, chal[i]);
        end
        cpu_write({8'h00, REG_COMPUTE}, 8'h00);
        for (int i = 0; i < 4; i++) begin
            read_expect(REG_RESPONSE0 + byte_t'(i), expected_response(chal[i], key));
        end
        report_test("register set", errs);

        errs = total_errors();
        apply_reset();
        // Nonzero challenges would leave nonzero responses if accepted
        for (int i = 0; i < 4; i++) begin
            cpu_write({8'h00, REG_CHALLENGE0 + byte_t'(i)}, next_random() | 8'h01);
        end
        cpu_write({8'h00, REG_COMPUTE}, 8'h00);
        for (int i = 0; i < 4; i++) begin
            read_expect(REG_RESPONSE0 + byte_t'(i), 8'h00);
        end
        report_test("locked writes", errs);

        $display("Tests run: %0d, passed: %0d, failed: %0d, errors: %0d",
                 test_count, test_count - fail_count, fail_count, total_errors());
        if (total_errors() == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
